/* logic/rv_secure_pkg.sv */
/*
 * Shared widths, word types and integrity status for the secure core wrapper.
 * Register words use an extended Hamming code, 32 data bits plus 7 check bits.
 */
package rv_secure_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned DataW    = 32;
  localparam int unsigned EccW     = 7;
  localparam int unsigned CodeW    = DataW + EccW;

  // Hamming check bits, the overall parity bit excluded
  localparam int unsigned HamW     = EccW - 1;

  ////////////////////
  // Code layout
  ////////////////////

  // Data in [31:0], c0..c5 in [37:32], overall parity on top
  localparam int unsigned CheckLsb  = DataW;
  localparam int unsigned CheckMsb  = DataW + HamW - 1;
  localparam int unsigned ParityBit = CodeW - 1;

  // Highest Hamming position, positions run from 1
  localparam int unsigned HamMaxPos = CodeW - 1;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [RegAddrW-1:0] rf_addr_t;
  typedef logic [CodeW-1:0]    rf_word_t;
  typedef logic [HamW-1:0]     syndrome_t;

  typedef enum logic [1:0] {
    EccOk     = 2'd0,
    EccSingle = 2'd1,
    EccDouble = 2'd2
  } ecc_status_e;

endpackage

/* logic/core_sleep_ctrl.sv */
/*
 * Core sleep control. Holds the sticky fetch enable and the registered busy
 * flag and combines them with the wake sources into the clock enable.
 */
`timescale 1ns/1ps

module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clock_en_o,
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic wake;

  // Fetch enable latches once and holds until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any of these keeps the core awake
  assign wake = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;

  assign clock_en_o   = fetch_enable_q & wake;
  assign core_sleep_o = ~clock_en_o;

endmodule

/* logic/regfile_ff.sv */
/*
 * Flip-flop register file of 32 integrity-coded words.
 * Two combinational read ports, one write port qualified by the clock enable.
 */
`timescale 1ns/1ps

module regfile_ff (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rv_secure_pkg::rf_addr_t raddr_a_i,
  output rv_secure_pkg::rf_word_t rdata_a_o,
  input  rv_secure_pkg::rf_addr_t raddr_b_i,
  output rv_secure_pkg::rf_word_t rdata_b_o,
  input  rv_secure_pkg::rf_addr_t waddr_i,
  input  rv_secure_pkg::rf_word_t wdata_i,
  input  logic                    we_i,
  input  logic                    clock_en_i
);

  rv_secure_pkg::rf_word_t [rv_secure_pkg::NumRegs-1:0] rf_reg;
  rv_secure_pkg::rf_word_t [rv_secure_pkg::NumRegs-1:1] rf_reg_q;
  logic [rv_secure_pkg::NumRegs-1:1] we_dec;
  logic                              wr_en;

  // Stands in for the gated clock of the core
  assign wr_en = we_i & clock_en_i;

  always_comb begin
    for (int unsigned i = 1; i < rv_secure_pkg::NumRegs; i++) begin
      we_dec[i] = wr_en & (waddr_i == rv_secure_pkg::rf_addr_t'(i));
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  // x0 has no flops
  for (genvar i = 1; i < rv_secure_pkg::NumRegs; i++) begin : gen_rf_flops
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg_q[i] <= wdata_i;
      end
    end
  end

  // All-zero word is a valid codeword, so x0 passes the checker
  assign rf_reg = {rf_reg_q, rv_secure_pkg::rf_word_t'('0)};

  ////////////////////
  // Read ports
  ////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

/* logic/secded_dec.sv */
/*
 * Extended Hamming check of one register word. Rebuilds the syndrome and the
 * overall parity and classifies the word as clean, single or double error.
 */
`timescale 1ns/1ps

module secded_dec (
  input  rv_secure_pkg::rf_word_t    word_i,
  output rv_secure_pkg::ecc_status_e status_o
);

  // Check bit k covers every Hamming position with bit k set
  function automatic rv_secure_pkg::syndrome_t calc_checks(
    logic [rv_secure_pkg::DataW-1:0] data
  );
    rv_secure_pkg::syndrome_t chk;
    int unsigned              d;
    chk = '0;
    d   = 0;
    for (int unsigned pos = 1; pos <= rv_secure_pkg::HamMaxPos; pos++) begin
      // Powers of two hold check bits, skip them
      if ((pos & (pos - 1)) != 0) begin
        for (int unsigned k = 0; k < rv_secure_pkg::HamW; k++) begin
          if (pos[k]) begin
            chk[k] = chk[k] ^ data[d];
          end
        end
        d++;
      end
    end
    return chk;
  endfunction

  rv_secure_pkg::syndrome_t syndrome;
  logic                     parity_err;

  assign syndrome = calc_checks(word_i[rv_secure_pkg::DataW-1:0]) ^
                    word_i[rv_secure_pkg::CheckMsb:rv_secure_pkg::CheckLsb];

  // Whole word including the parity bit XORs to zero when clean
  assign parity_err = ^word_i;

  always_comb begin
    if (parity_err) begin
      // Odd number of flips, treated as one
      status_o = rv_secure_pkg::EccSingle;
    end else if (syndrome != '0) begin
      status_o = rv_secure_pkg::EccDouble;
    end else begin
      status_o = rv_secure_pkg::EccOk;
    end
  end

endmodule

/* logic/rf_integrity_monitor.sv */
/*
 * Integrity monitor on both register file read ports.
 * Single errors raise the minor alert, double errors the major alert.
 */
`timescale 1ns/1ps

module rf_integrity_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rv_secure_pkg::rf_word_t rdata_a_i,
  input  rv_secure_pkg::rf_word_t rdata_b_i,
  output logic                    alert_minor_o,
  output logic                    alert_major_o
);

  rv_secure_pkg::ecc_status_e status_a;
  rv_secure_pkg::ecc_status_e status_b;
  logic                       major_d;
  logic                       minor_d;

  secded_dec u_dec_a (
    .word_i   (rdata_a_i),
    .status_o (status_a)
  );

  secded_dec u_dec_b (
    .word_i   (rdata_b_i),
    .status_o (status_b)
  );

  // Major wins over minor across ports
  assign major_d = (status_a == rv_secure_pkg::EccDouble) |
                   (status_b == rv_secure_pkg::EccDouble);
  assign minor_d = ~major_d &
                   ((status_a == rv_secure_pkg::EccSingle) |
                    (status_b == rv_secure_pkg::EccSingle));

  ////////////////////
  // Alert flops
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_minor_o <= 1'b0;
      alert_major_o <= 1'b0;
    end else begin
      alert_minor_o <= minor_d;
      alert_major_o <= major_d;
    end
  end

endmodule

/* logic/rv_secure_top.sv */
/*
 * Secure core wrapper without the core. Sleep control, integrity-coded
 * register file and the read port integrity monitor.
 */
`timescale 1ns/1ps

module rv_secure_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Core control and wake sources
  input  logic                    fetch_enable_i,
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_nm_i,

  // Register file ports, words arrive already encoded
  input  rv_secure_pkg::rf_addr_t rf_raddr_a_i,
  input  rv_secure_pkg::rf_addr_t rf_raddr_b_i,
  input  rv_secure_pkg::rf_addr_t rf_waddr_i,
  input  rv_secure_pkg::rf_word_t rf_wdata_i,
  input  logic                    rf_we_i,
  output rv_secure_pkg::rf_word_t rf_rdata_a_o,
  output rv_secure_pkg::rf_word_t rf_rdata_b_o,

  // Status
  output logic                    core_sleep_o,
  output logic                    alert_minor_o,
  output logic                    alert_major_o
);

  logic clock_en;

  ////////////////////
  // Sleep control
  ////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .debug_req_i    (debug_req_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .clock_en_o     (clock_en),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////
  // Register file
  ////////////////////

  regfile_ff u_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .raddr_a_i  (rf_raddr_a_i),
    .rdata_a_o  (rf_rdata_a_o),
    .raddr_b_i  (rf_raddr_b_i),
    .rdata_b_o  (rf_rdata_b_o),
    .waddr_i    (rf_waddr_i),
    .wdata_i    (rf_wdata_i),
    .we_i       (rf_we_i),
    .clock_en_i (clock_en)
  );

  ////////////////////
  // Integrity alerts
  ////////////////////

  // Watches the same words the read ports return
  rf_integrity_monitor u_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rdata_a_i     (rf_rdata_a_o),
    .rdata_b_i     (rf_rdata_b_o),
    .alert_minor_o (alert_minor_o),
    .alert_major_o (alert_major_o)
  );

endmodule

/* verification/rv_secure_asserts.sv */
/*
 * Concurrent checks on the wrapper outputs, bound into the top level.
 */
`timescale 1ns/1ps

module rv_secure_asserts (
  input logic                    clk_i,
  input logic                    rst_ni,
  input rv_secure_pkg::rf_addr_t raddr_a_i,
  input rv_secure_pkg::rf_addr_t raddr_b_i,
  input rv_secure_pkg::rf_word_t rdata_a_i,
  input rv_secure_pkg::rf_word_t rdata_b_i,
  input logic                    alert_minor_i,
  input logic                    alert_major_i
);

  a_alerts_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_minor_i, alert_major_i}))
    else $error("Alert outputs are unknown after reset");

  // Major wins, so both never show together
  a_alerts_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alert_minor_i && alert_major_i))
    else $error("Minor and major alerts are high together");

  a_x0_zero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_a_i == '0) |-> (rdata_a_i == '0))
    else $error("Register x0 on port a does not read as zero");

  a_x0_zero_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_b_i == '0) |-> (rdata_b_i == '0))
    else $error("Register x0 on port b does not read as zero");

endmodule

bind rv_secure_top rv_secure_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .raddr_a_i     (rf_raddr_a_i),
  .raddr_b_i     (rf_raddr_b_i),
  .rdata_a_i     (rf_rdata_a_o),
  .rdata_b_i     (rf_rdata_b_o),
  .alert_minor_i (alert_minor_o),
  .alert_major_i (alert_major_o)
);

/* verification/tb_top.sv */
/*
 * Testbench for the secure core wrapper. A register and alert model runs on
 * the falling edge and is checked every cycle, with directed checks per behavior.
 */
`timescale 1ns/1ps

module tb_top;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    fetch_enable_i, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i;
  rv_secure_pkg::rf_addr_t rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  rv_secure_pkg::rf_word_t rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic                    rf_we_i, core_sleep_o, alert_minor_o, alert_major_o;

  // Expected words and error class per register (0 clean, 1 single, 2 double)
  rv_secure_pkg::rf_word_t model_q [rv_secure_pkg::NumRegs];
  logic [1:0]              cls_q [rv_secure_pkg::NumRegs];
  logic [1:0]              wr_class;
  logic                    fe_q, busy_q, exp_minor, exp_major;
  integer                  seed = 42;

  rv_secure_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input rv_secure_pkg::rf_word_t exp,
                            input rv_secure_pkg::rf_word_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Extended Hamming encoder over positions 1..38 with checks at powers of two
  function automatic rv_secure_pkg::rf_word_t encode_word(input logic [31:0] data);
    logic [38:1]             ham;
    logic [5:0]              chk;
    rv_secure_pkg::rf_word_t word;
    int unsigned             d;
    ham = '0;
    chk = '0;
    d   = 0;
    for (int unsigned p = 1; p <= 38; p++) begin
      if (!(p inside {1, 2, 4, 8, 16, 32})) begin
        ham[p] = data[d];
        d++;
      end
    end
    for (int unsigned p = 1; p <= 38; p++) begin
      for (int unsigned k = 0; k < 6; k++) begin
        if (p[k]) begin
          chk[k] = chk[k] ^ ham[p];
        end
      end
    end
    word     = {1'b0, chk, data};
    word[38] = ^word;
    return word;
  endfunction

  ////////////////////
  // Checker
  ////////////////////

  always @(negedge clk_i) begin
    logic wake;
    if (!rst_ni) begin
      for (int i = 0; i < rv_secure_pkg::NumRegs; i++) begin
        model_q[i] = '0;
        cls_q[i]   = 2'd0;
      end
      fe_q      = 1'b0;
      busy_q    = 1'b0;
      exp_minor = 1'b0;
      exp_major = 1'b0;
    end else begin
      wake = fe_q & (busy_q | debug_req_i | irq_pending_i | irq_nm_i);
      check_word("read_port_a", model_q[rf_raddr_a_i], rf_rdata_a_o);
      check_word("read_port_b", model_q[rf_raddr_b_i], rf_rdata_b_o);
      check_flag("core_sleep", ~wake, core_sleep_o);
      check_flag("alert_minor", exp_minor, alert_minor_o);
      check_flag("alert_major", exp_major, alert_major_o);
      // Alerts register the words selected now
      exp_major = (cls_q[rf_raddr_a_i] == 2'd2) || (cls_q[rf_raddr_b_i] == 2'd2);
      exp_minor = !exp_major && ((cls_q[rf_raddr_a_i] == 2'd1) || (cls_q[rf_raddr_b_i] == 2'd1));
      if (rf_we_i && wake && (rf_waddr_i != '0)) begin
        model_q[rf_waddr_i] = rf_wdata_i;
        cls_q[rf_waddr_i]   = wr_class;
      end
      fe_q   = fe_q | fetch_enable_i;
      busy_q = core_busy_i;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic set_wake(input logic busy, input logic dbg, input logic irq, input logic nmi);
    @(posedge clk_i);
    core_busy_i   <= busy;
    debug_req_i   <= dbg;
    irq_pending_i <= irq;
    irq_nm_i      <= nmi;
  endtask

  task automatic write_reg(input rv_secure_pkg::rf_addr_t addr,
                           input rv_secure_pkg::rf_word_t word, input logic [1:0] cls);
    @(posedge clk_i);
    rf_waddr_i <= addr;
    rf_wdata_i <= word;
    wr_class   <= cls;
    rf_we_i    <= 1'b1;
    @(posedge clk_i);
    rf_we_i    <= 1'b0;
  endtask

  task automatic select_regs(input rv_secure_pkg::rf_addr_t a, input rv_secure_pkg::rf_addr_t b);
    @(posedge clk_i);
    rf_raddr_a_i <= a;
    rf_raddr_b_i <= b;
    @(negedge clk_i);
  endtask

  task automatic wait_awake(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk_i);
    while (core_sleep_o !== 1'b0) begin
      if (n >= max_cycles) begin
        abort_run("Timeout while waiting for the core to leave sleep");
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  // Stores a word with one or two flipped bits and reads it on one port
  task automatic corrupt_check(input int flips, input logic on_b);
    rv_secure_pkg::rf_addr_t addr;
    rv_secure_pkg::rf_word_t word;
    int unsigned             p1, p2;
    addr = rv_secure_pkg::rf_addr_t'(rand32());
    if (addr == '0) begin
      addr = 5'd1;
    end
    p1   = rand32() % rv_secure_pkg::CodeW;
    p2   = (p1 + 1 + rand32() % (rv_secure_pkg::CodeW - 1)) % rv_secure_pkg::CodeW;
    word = encode_word(rand32()) ^ (rv_secure_pkg::rf_word_t'(1) << p1);
    if (flips == 2) begin
      word = word ^ (rv_secure_pkg::rf_word_t'(1) << p2);
    end
    write_reg(addr, word, 2'(flips));
    if (on_b) begin
      select_regs('0, addr);
    end else begin
      select_regs(addr, '0);
    end
    @(negedge clk_i);
    check_flag(flips == 1 ? "single_minor" : "double_minor", flips == 1, alert_minor_o);
    check_flag(flips == 1 ? "single_major" : "double_major", flips == 2, alert_major_o);
    select_regs('0, '0);
  endtask

  initial begin
    logic [31:0]             r;
    rv_secure_pkg::rf_addr_t addr;
    rv_secure_pkg::rf_word_t word;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    core_busy_i    = 1'b0;
    debug_req_i    = 1'b0;
    irq_pending_i  = 1'b0;
    irq_nm_i       = 1'b0;
    rf_raddr_a_i   = '0;
    rf_raddr_b_i   = '0;
    rf_waddr_i     = '0;
    rf_wdata_i     = '0;
    rf_we_i        = 1'b0;
    wr_class       = 2'd0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Writes are dropped until fetch enable
    @(negedge clk_i);
    check_flag("reset_sleep", 1'b1, core_sleep_o);
    check_flag("reset_minor", 1'b0, alert_minor_o);
    check_flag("reset_major", 1'b0, alert_major_o);
    set_wake(1'b0, 1'b0, 1'b1, 1'b0);
    write_reg(5'd5, encode_word(rand32()), 2'd0);
    select_regs(5'd5, 5'd5);
    check_word("pre_fetch_write", '0, rf_rdata_a_o);

    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    @(posedge clk_i);
    fetch_enable_i <= 1'b0;
    repeat (40) begin
      r = rand32();
      @(posedge clk_i);
      core_busy_i   <= r[0];
      debug_req_i   <= r[1] & r[2];
      irq_pending_i <= r[3] & r[4];
      irq_nm_i      <= r[5] & r[6] & r[7];
      rf_we_i       <= r[8];
      rf_waddr_i    <= r[13:9];
      rf_raddr_a_i  <= r[18:14];
      rf_raddr_b_i  <= r[23:19];
      rf_wdata_i    <= encode_word(rand32());
      wr_class      <= 2'd0;
    end
    set_wake(1'b0, 1'b0, 1'b1, 1'b0);
    rf_we_i <= 1'b0;
    wait_awake(4);
    word = encode_word(rand32());
    write_reg(5'd9, word, 2'd0);
    set_wake(1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_flag("sleep_entered", 1'b1, core_sleep_o);
    write_reg(5'd9, encode_word(rand32()), 2'd0);
    select_regs(5'd9, 5'd9);
    check_word("asleep_write", word, rf_rdata_a_o);

    set_wake(1'b0, 1'b0, 1'b1, 1'b0);
    wait_awake(4);
    repeat (30) begin
      addr = rv_secure_pkg::rf_addr_t'(rand32());
      word = encode_word(rand32());
      write_reg(addr, word, 2'd0);
      select_regs(addr, addr);
      if (addr == '0) begin
        word = '0;
      end
      check_word("write_read_a", word, rf_rdata_a_o);
      check_word("write_read_b", word, rf_rdata_b_o);
    end
    write_reg('0, encode_word(32'hffff_ffff), 2'd0);
    select_regs('0, '0);
    check_word("x0_write", '0, rf_rdata_a_o);

    repeat (8) corrupt_check(1, 1'b0);
    repeat (8) corrupt_check(2, 1'b1);

    // Single error on port a and double error on port b
    write_reg(5'd3, encode_word(rand32()) ^ 39'h1, 2'd1);
    write_reg(5'd4, encode_word(rand32()) ^ 39'h3, 2'd2);
    select_regs(5'd3, 5'd4);
    @(negedge clk_i);
    check_flag("mixed_minor", 1'b0, alert_minor_o);
    check_flag("mixed_major", 1'b1, alert_major_o);

    select_regs('0, '0);
    @(negedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* list.f */
logic/rv_secure_pkg.sv
logic/core_sleep_ctrl.sv
logic/regfile_ff.sv
logic/secded_dec.sv
logic/rf_integrity_monitor.sv
logic/rv_secure_top.sv
verification/rv_secure_asserts.sv
verification/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_sim \
  || { echo "Build failed"; exit 1; }

out="$(./obj_dir/tb_sim 2>&1)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
